// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_char_layer
FILELIST   := all.f
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Simulation failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	test $$status -eq 0 && ! grep -q "$(FAIL_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
+incdir+.
char_video_pkg.sv
char_map_pkg.sv
char_vram.sv
char_scan_decode.sv
char_scroll_latch.sv
char_pixel_shift.sv
char_layer.sv
char_layer_assertions.sv
tb_char_layer.sv

// File: char_config.svh
// Build constants for the character layer; the board model is fixed at compile time here
`ifndef CHAR_CONFIG_SVH
`define CHAR_CONFIG_SVH

// Board model, 0 = model A, 1 = model B
`define CHAR_MODEL_B 1

// Map RAM is 2K words of 16 bits
`define CHAR_RAM_AW 11

// hdump[8:4] value of the row-scroll read slot
`define CHAR_ROW_READ 5'd8

// Mirror bases used when the screen is flipped
`define CHAR_VFLIP_BASE 9'd223
`define CHAR_HFLIP_BASE 9'ha3

`endif

// File: char_layer.sv
// Character layer top; graphics ROM data is expected one clock after char_addr
`timescale 1ns/1ps
`include "char_config.svh"

module char_layer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  logic                    alt_en,
    // CPU port
    input  logic                    char_cs,
    input  logic [`CHAR_RAM_AW-1:0] cpu_addr,
    input  logic [15:0]             cpu_dout,
    input  logic [1:0]              dsn,        // Active-low byte strobes
    output logic [15:0]             cpu_din,
    // Graphics ROM
    output logic [12:0]             char_addr,
    input  logic [char_video_pkg::PLANES*char_video_pkg::PLANE_W-1:0] char_data,
    // Scroll values for the scroll layers
    output logic                    scr_start,
    output logic [9:0]              rowscr1,
    output logic [9:0]              rowscr2,
    output logic                    altscr1,
    output logic                    altscr2,
    input  char_video_pkg::scan_t   scr1_hscan,
    input  char_video_pkg::scan_t   scr2_hscan,
    output char_video_pkg::scan_t   colscr1,
    output char_video_pkg::scan_t   colscr2,
    output logic                    col_busy1,
    output logic                    col_busy2,
    // Video timing
    input  logic                    flip,
    input  char_video_pkg::scan_t   vrender,
    input  char_video_pkg::scan_t   vdump,
    input  char_video_pkg::scan_t   hdump,
    output char_video_pkg::pixel_t  pxl
);

    logic [1:0]              we;
    logic [`CHAR_RAM_AW-1:0] scan_addr;
    char_map_pkg::map_word_u scan_word;
    logic                    row_rd;
    logic                    col_rd;
    logic [2:0]              vf_row;

    assign we = ~dsn & {2{char_cs}};   // Byte enables

    char_vram u_vram (
        .clk       (clk),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .we        (we),
        .cpu_din   (cpu_din),
        .scan_addr (scan_addr),
        .scan_word (scan_word)
    );

    // Decode
    char_scan_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .flip       (flip),
        .hdump      (hdump),
        .vdump      (vdump),
        .vrender    (vrender),
        .scr1_hscan (scr1_hscan),
        .scr2_hscan (scr2_hscan),
        .scan_addr  (scan_addr),
        .row_rd     (row_rd),
        .col_rd     (col_rd),
        .vf_row     (vf_row),
        .scr_start  (scr_start)
    );

    // Execute
    char_scroll_latch u_execute (
        .clk       (clk),
        .rst       (rst),
        .row_rd    (row_rd),
        .col_rd    (col_rd),
        .hdump     (hdump),
        .scan_word (scan_word),
        .rowscr1   (rowscr1),
        .rowscr2   (rowscr2),
        .altscr1   (altscr1),
        .altscr2   (altscr2),
        .colscr1   (colscr1),
        .colscr2   (colscr2),
        .col_busy1 (col_busy1),
        .col_busy2 (col_busy2)
    );

    // Result
    char_pixel_shift u_result (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .hdump     (hdump),
        .flip      (flip),
        .alt_en    (alt_en),
        .vf_row    (vf_row),
        .scan_word (scan_word),
        .char_data (char_data),
        .char_addr (char_addr),
        .pxl       (pxl)
    );

endmodule

// File: char_layer_assertions.sv
// Bound checks on char_layer; slot timing is judged from the raw hdump input one clock back
`timescale 1ns/1ps
`include "char_config.svh"

module char_layer_assertions (
    input logic                   clk,
    input logic                   rst,
    input char_video_pkg::scan_t  hdump,
    input logic [9:0]             rowscr1,
    input logic [9:0]             rowscr2,
    input char_video_pkg::scan_t  colscr1,
    input char_video_pkg::scan_t  colscr2,
    input logic                   col_busy1,
    input logic                   col_busy2,
    input char_video_pkg::pixel_t pxl
);

    // Registers cleared while reset is held
    a_reset_state: assert property (@(posedge clk) rst && $past(rst) |->
        rowscr1 == 0 && rowscr2 == 0 && colscr1 == 0 && colscr2 == 0 &&
        !col_busy1 && !col_busy2 && pxl == 0)
        else $error("Outputs not cleared during reset");

    a_busy_excl: assert property (@(posedge clk) disable iff (rst) !(col_busy1 && col_busy2))
        else $error("Both column busy flags high");

    // Busy one clock after a column slot of matching parity
    a_busy1_slot: assert property (@(posedge clk) disable iff (rst)
        col_busy1 |-> $past(hdump[2:0] < 3'd6 && !hdump[0]))
        else $error("col_busy1 high outside an even column slot");

    a_busy2_slot: assert property (@(posedge clk) disable iff (rst)
        col_busy2 |-> $past(hdump[2:0] < 3'd6 && hdump[0]))
        else $error("col_busy2 high outside an odd column slot");

    // Row words land only in the half of the row slot for their layer
    a_row1_slot: assert property (@(posedge clk) disable iff (rst)
        rowscr1 != $past(rowscr1) |->
        $past(hdump[8:4] == `CHAR_ROW_READ && !hdump[3] && hdump[2:0] >= 3'd6))
        else $error("rowscr1 changed outside its row slot");

    a_row2_slot: assert property (@(posedge clk) disable iff (rst)
        rowscr2 != $past(rowscr2) |->
        $past(hdump[8:4] == `CHAR_ROW_READ && hdump[3] && hdump[2:0] >= 3'd6))
        else $error("rowscr2 changed outside its row slot");

    // Column words land only inside a column slot
    a_col_slot: assert property (@(posedge clk) disable iff (rst)
        colscr1 != $past(colscr1) || colscr2 != $past(colscr2) |->
        $past(hdump[2:0] < 3'd6))
        else $error("Column scroll changed outside a column slot");

endmodule

bind char_layer char_layer_assertions u_assert (.*);

// File: char_map_pkg.sv
// Map RAM word layouts; a word is read either as a tile entry or as a scroll entry
package char_map_pkg;

    // Tile entry in raw RAM layout, decoding depends on model and alt_en
    typedef struct packed {
        logic       prio;       // Priority on model B
        logic [2:0] spare;      // Not decoded
        logic [3:0] attr_raw;   // Palette bits, bit 0 is code MSB on plain model B
        logic [7:0] code;       // Tile code low byte
    } tile_entry_t;

    // Entry of the row- or column-scroll table
    typedef struct packed {
        logic       alt;        // Alternate scroll select, model B only
        logic [4:0] spare;
        logic [9:0] value;      // Column scroll uses the low 9 bits
    } scroll_entry_t;

    // The one RAM word, seen two ways
    typedef union packed {
        tile_entry_t   tile;
        scroll_entry_t scroll;
    } map_word_u;

endpackage

// File: char_pixel_shift.sv
// Pixel shifter; char_data must be valid on the pxl_cen where hdump[2:0] is 7
`timescale 1ns/1ps
`include "char_config.svh"

module char_pixel_shift (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  char_video_pkg::scan_t   hdump,
    input  logic                    flip,
    input  logic                    alt_en,     // Alternate model B encoding
    input  logic [2:0]              vf_row,
    input  char_map_pkg::map_word_u scan_word,
    input  logic [char_video_pkg::PLANES*char_video_pkg::PLANE_W-1:0] char_data,
    output logic [12:0]             char_addr,
    output char_video_pkg::pixel_t  pxl
);

    localparam bit MODEL_B = `CHAR_MODEL_B;
    localparam int NP      = char_video_pkg::PLANES;
    localparam int PW      = char_video_pkg::PLANE_W;

    char_map_pkg::tile_entry_t tile;
    logic [8:0]            code;
    logic [8:0]            code_next;
    logic [3:0]            attr_next;
    logic [3:0]            attr0;      // Attribute of the tile being fetched
    logic [3:0]            attr;       // Attribute of the tile on screen
    logic [NP-1:0][PW-1:0] planes;
    logic [NP-1:0]         colour;

    assign tile      = scan_word.tile;
    assign char_addr = {code, vf_row, 1'b0};   // Even half of the ROM line

    // Tile entry decode
    always_comb begin
        if (MODEL_B && !alt_en) begin
            code_next = {tile.attr_raw[0], tile.code};   // 512 tiles
        end else begin
            code_next = {1'b0, tile.code};
        end
        if (!MODEL_B) begin
            attr_next = tile.attr_raw;
        end else if (alt_en) begin
            attr_next = {tile.prio, tile.attr_raw[2:0]};
        end else begin
            attr_next = {tile.prio, tile.attr_raw[3:1]};
        end
    end

    // Leading bit of each plane, MSB normally and LSB when flipped
    always_comb begin
        for (int p = 0; p < NP; p++) begin
            colour[p] = flip ? planes[p][0] : planes[p][PW-1];
        end
    end

    assign pxl = {attr, colour};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            code   <= '0;
            attr0  <= '0;
            attr   <= '0;
            planes <= '0;
        end else if (pxl_cen) begin
            if (hdump[2:0] == 3'd7) begin
                // Tile boundary
                code   <= code_next;
                planes <= char_data;
                attr0  <= attr_next;
                attr   <= attr0;
            end else begin
                for (int p = 0; p < NP; p++) begin
                    planes[p] <= flip ? planes[p] >> 1 : planes[p] << 1;
                end
            end
        end
    end

endmodule

// File: char_scan_decode.sv
// Video address decode; flipped coordinates lag hdump/vdump by one clock, slots use raw hdump
`timescale 1ns/1ps
`include "char_config.svh"

module char_scan_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flip,
    input  char_video_pkg::scan_t   hdump,
    input  char_video_pkg::scan_t   vdump,
    input  char_video_pkg::scan_t   vrender,
    input  char_video_pkg::scan_t   scr1_hscan,
    input  char_video_pkg::scan_t   scr2_hscan,
    output logic [`CHAR_RAM_AW-1:0] scan_addr,
    output logic                    row_rd,
    output logic                    col_rd,
    output logic [2:0]              vf_row,     // Line inside the tile
    output logic                    scr_start
);

    localparam bit MODEL_B = `CHAR_MODEL_B;

    char_video_pkg::scan_t vf;          // Flipped vdump
    char_video_pkg::scan_t vfr;         // Flipped vrender, matches scroll layer timing
    char_video_pkg::scan_t hf;          // Flipped hdump
    char_video_pkg::scan_t hscan_mux;   // Column being drawn by the selected layer

    // Mirror coordinates
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vf  <= '0;
            vfr <= '0;
            hf  <= '0;
        end else begin
            vf  <= flip ? `CHAR_VFLIP_BASE - vdump   : vdump;
            vfr <= flip ? `CHAR_VFLIP_BASE - vrender : vrender;
            hf  <= flip ? `CHAR_HFLIP_BASE - hdump   : hdump;
        end
    end

    assign vf_row    = vf[2:0];
    assign scr_start = hdump[8:4] == `CHAR_ROW_READ + 5'd1;   // Line start for scroll layers

    // Slot strobes
    assign row_rd = hdump[8:4] == `CHAR_ROW_READ && hdump[2:0] >= 3'd6;
    assign col_rd = hdump[2:0] < 3'd6;

    // Even hdump serves layer 1, odd serves layer 2
    assign hscan_mux = (hdump[0] ? scr2_hscan : scr1_hscan) + 9'd1;

    always_comb begin
        // Tile fetch runs two columns ahead of the shifter
        scan_addr = {vf[7:3], hf[8:3] + 6'd2};
        if (row_rd) begin
            // Row table at 0x1F, one word per tile row and layer
            scan_addr = MODEL_B ? {5'h1f, hdump[3], vfr[7:3]}
                                : {5'h1f, vfr[7:3], hdump[3]};
        end
        if (col_rd) begin
            // Column table at 0x1E
            scan_addr = MODEL_B ? {5'h1e, hdump[0], hscan_mux[8:4]}
                                : {5'h1e, hscan_mux[8:4], hdump[0]};
        end
    end

endmodule

// File: char_scroll_latch.sv
// Scroll capture; scan_word must lag the slot strobes by exactly one clock
`timescale 1ns/1ps
`include "char_config.svh"

module char_scroll_latch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      row_rd,
    input  logic                      col_rd,
    input  char_video_pkg::scan_t     hdump,
    input  char_map_pkg::map_word_u   scan_word,
    output logic [9:0]                rowscr1,
    output logic [9:0]                rowscr2,
    output logic                      altscr1,
    output logic                      altscr2,
    output char_video_pkg::scan_t     colscr1,
    output char_video_pkg::scan_t     colscr2,
    output logic                      col_busy1,
    output logic                      col_busy2
);

    localparam bit MODEL_B = `CHAR_MODEL_B;

    logic row_rdl;      // Strobes one clock late
    logic col_rdl;
    logic hdump0l;      // Layer select of the word now on scan_word
    logic alt_bit;

    assign alt_bit = MODEL_B & scan_word.scroll.alt;   // Always zero on model A

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row_rdl   <= 1'b0;
            col_rdl   <= 1'b0;
            hdump0l   <= 1'b0;
            rowscr1   <= '0;
            rowscr2   <= '0;
            altscr1   <= 1'b0;
            altscr2   <= 1'b0;
            colscr1   <= '0;
            colscr2   <= '0;
            col_busy1 <= 1'b0;
            col_busy2 <= 1'b0;
        end else begin
            row_rdl   <= row_rd;
            col_rdl   <= col_rd;
            hdump0l   <= hdump[0];
            col_busy1 <= col_rd & ~hdump[0];
            col_busy2 <= col_rd &  hdump[0];
            // Word valid once the strobe has been high for a clock
            if (row_rdl && row_rd) begin
                if (!hdump[3]) begin
                    rowscr1 <= scan_word.scroll.value;
                    altscr1 <= alt_bit;
                end else begin
                    rowscr2 <= scan_word.scroll.value;
                    altscr2 <= alt_bit;
                end
            end
            if (col_rdl && col_rd) begin
                if (!hdump0l) colscr1 <= scan_word.scroll.value[8:0];
                else          colscr2 <= scan_word.scroll.value[8:0];
            end
        end
    end

endmodule

// File: char_video_pkg.sv
// Video timing types; scan counters are 9 bits and pixels carry no palette lookup
package char_video_pkg;

    // Horizontal or vertical scan position
    typedef logic [8:0] scan_t;

    // {priority, palette[2:0], colour[2:0]}
    typedef logic [6:0] pixel_t;

    // Graphics ROM word holds one byte per colour plane
    localparam int PLANES  = 3;
    localparam int PLANE_W = 8;

endpackage

// File: char_vram.sv
// Map RAM; read-during-write on the CPU port returns the old word, no reset on contents
`timescale 1ns/1ps
`include "char_config.svh"

module char_vram (
    input  logic                    clk,
    // CPU port
    input  logic [`CHAR_RAM_AW-1:0] cpu_addr,
    input  logic [15:0]             cpu_dout,
    input  logic [1:0]              we,         // One enable per byte lane
    output logic [15:0]             cpu_din,
    // Video port, read only
    input  logic [`CHAR_RAM_AW-1:0] scan_addr,
    output logic [15:0]             scan_word
);

    localparam int DEPTH = 1 << `CHAR_RAM_AW;

    logic [15:0] mem [0:DEPTH-1];

    // CPU side, byte lane writes
    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (we[b]) begin
                mem[cpu_addr][b*8 +: 8] <= cpu_dout[b*8 +: 8];
            end
        end
        cpu_din <= mem[cpu_addr];   // Old data on a write cycle
    end

    // Video side, one clock latency
    always_ff @(posedge clk) begin
        scan_word <= mem[scan_addr];
    end

endmodule

// File: tb_char_layer.sv
// Directed testbench; the graphics ROM answers one clock after char_addr and the scan never stops
`timescale 1ns/1ps
`include "char_config.svh"

module tb_char_layer;

    localparam int PERIOD     = 100;
    localparam int RST_CYCLES = 10;
    localparam int LINE_CLKS  = 512 * 4;            // hdump steps every fourth clock
    localparam int MAP_WORDS  = 1 << `CHAR_RAM_AW;
    localparam bit MODEL_B    = `CHAR_MODEL_B;
    localparam longint WATCHDOG_CLKS =
        2 * (RST_CYCLES + 100 + 3 * (64 + 2 * LINE_CLKS) + 2 * (MAP_WORDS + LINE_CLKS));
    localparam logic [31:0] SEED = 32'd49310;
    localparam logic [15:0] TILE = 16'ha5c3;

    logic        clk = 1'b0;
    logic        rst;
    logic        pxl_cen = 1'b0;
    logic [1:0]  cen_cnt = 2'd0;
    logic        alt_en;
    logic        char_cs;
    logic [10:0] cpu_addr;
    logic [15:0] cpu_dout;
    logic [1:0]  dsn;
    logic [15:0] cpu_din;
    logic [12:0] char_addr;
    logic [23:0] char_data = '0;
    logic        scr_start;
    logic [9:0]  rowscr1, rowscr2;
    logic        altscr1, altscr2;
    logic [8:0]  scr1_hscan, scr2_hscan;
    logic [8:0]  colscr1, colscr2;
    logic        col_busy1, col_busy2;
    logic        flip;
    logic [8:0]  vrender;
    logic [8:0]  vdump = '0;
    logic [8:0]  hdump = '0;
    logic [6:0]  pxl;

    int          errors = 0;
    int          checks = 0;
    int          tests  = 0;
    int          failed_tests = 0;
    logic [31:0] rng_state = SEED;
    logic [15:0] table_words [0:63];                 // Last words written to a scroll table

    char_layer uut (.*);

    always #(PERIOD / 2) clk = ~clk;

    // Video timing with pxl_cen one clock in four
    always @(posedge clk) begin
        if (rst) begin
            cen_cnt <= 2'd0;
            pxl_cen <= 1'b0;
            hdump   <= '0;
            vdump   <= '0;
        end else begin
            cen_cnt <= cen_cnt + 2'd1;
            pxl_cen <= cen_cnt == 2'd2;
            if (pxl_cen) begin
                hdump <= hdump + 9'd1;                // Wraps after 0x1FF
                if (hdump == 9'h1ff) vdump <= vdump + 9'd1;
            end
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Three plane bytes from every bit of the ROM address
    function automatic logic [23:0] rom_word(input logic [12:0] a);
        logic [31:0] r;
        r = xorshift(xorshift(SEED ^ {19'd0, a}));
        return r[23:0];
    endfunction

    function automatic logic [15:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state[15:0];
    endfunction

    // ROM model
    always @(posedge clk) char_data <= rom_word(char_addr);

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic cpu_write(input logic [10:0] a, input logic [15:0] d, input logic [1:0] s);
        @(posedge clk);
        char_cs  <= 1'b1;
        cpu_addr <= a;
        cpu_dout <= d;
        dsn      <= s;
    endtask

    task automatic cpu_idle();
        @(posedge clk);
        char_cs <= 1'b0;
        dsn     <= 2'b11;
    endtask

    task automatic cpu_read(input logic [10:0] a, output logic [15:0] d);
        @(posedge clk);
        char_cs  <= 1'b0;
        cpu_addr <= a;
        @(posedge clk);
        @(negedge clk);
        d = cpu_din;                                  // One clock after the address
    endtask

    // Waits on negedges so hdump is stable when compared
    task automatic wait_hdump(input logic [8:0] v);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (hdump != v && n < 2 * LINE_CLKS + 8);
        if (hdump != v) begin
            $display("Timed out waiting for hdump to reach 0x%h", v);
            errors++;
        end
    endtask

    task automatic wait_phase(input logic [2:0] p);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (hdump[2:0] != p && n < 64);
        if (hdump[2:0] != p) begin
            $display("Timed out waiting for tile phase %0d", p);
            errors++;
        end
    endtask

    // Returns at the first negedge after a tile load with the loaded ROM word
    task automatic wait_load(output logic [23:0] loaded);
        logic [2:0] prev;
        wait_phase(3'd6);
        prev = hdump[2:0];
        forever begin
            @(negedge clk);
            if (prev == 3'd7 && hdump[2:0] == 3'd0) break;
            if (hdump[2:0] == 3'd7) loaded = rom_word(char_addr);   // Address stable in phase 7
            prev = hdump[2:0];
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_before);
            failed_tests++;
        end
    endtask

    task automatic test_reset_state();
        int e;
        e = errors;
        @(negedge clk);
        check_value("rowscr1", rowscr1, 0);
        check_value("rowscr2", rowscr2, 0);
        check_value("altscr1", altscr1, 0);
        check_value("altscr2", altscr2, 0);
        check_value("colscr1", colscr1, 0);
        check_value("colscr2", colscr2, 0);
        check_value("col_busy1", col_busy1, 0);
        check_value("col_busy2", col_busy2, 0);
        check_value("pxl", pxl, 0);
        report_test("reset state", e);
    endtask

    task automatic test_cpu_bytes();
        int e;
        logic [10:0] a;
        logic [15:0] r;
        logic [15:0] base, upd, got, exp;
        e = errors;
        for (int p = 0; p < 4; p++) begin
            r    = next_rand();
            a    = {1'b0, r[9:0]};                    // Clear of the scroll tables
            base = next_rand();
            upd  = next_rand();
            cpu_write(a, base, 2'b00);
            cpu_write(a, upd, p[1:0]);
            cpu_idle();
            cpu_read(a, got);
            exp[7:0]  = p[0] ? base[7:0]  : upd[7:0];   // Low strobe writes the lane
            exp[15:8] = p[1] ? base[15:8] : upd[15:8];
            check_value("cpu_din", got, exp);
        end
        report_test("cpu byte writes", e);
    endtask

    task automatic fill_table(input logic [4:0] tbl);
        for (int i = 0; i < 64; i++) begin
            table_words[i] = next_rand();
            cpu_write({tbl, i[5:0]}, table_words[i], 2'b00);
        end
        cpu_idle();
    endtask

    task automatic test_row_scroll();
        int e;
        logic [5:0] i1, i2;
        logic [8:0] vr;
        e  = errors;
        vr = 9'h05d;
        @(posedge clk);
        flip    <= 1'b0;
        vrender <= vr;
        fill_table(5'h1f);
        i1 = MODEL_B ? {1'b0, vr[7:3]} : {vr[7:3], 1'b0};
        i2 = MODEL_B ? {1'b1, vr[7:3]} : {vr[7:3], 1'b1};
        wait_hdump(9'h070);                           // Before the slot
        check_value("scr_start", scr_start, 0);
        wait_hdump(9'h090);                           // After it
        check_value("scr_start", scr_start, 1);       // First tile row past the row slot
        check_value("rowscr1", rowscr1, table_words[i1][9:0]);
        check_value("rowscr2", rowscr2, table_words[i2][9:0]);
        check_value("altscr1", altscr1, MODEL_B & table_words[i1][15]);
        check_value("altscr2", altscr2, MODEL_B & table_words[i2][15]);
        report_test("row scroll", e);
    endtask

    task automatic test_col_scroll();
        int e;
        logic [8:0] h1, h2, hs;
        logic [5:0] i1, i2;
        e = errors;
        @(posedge clk);
        scr1_hscan <= 9'h0a5;
        scr2_hscan <= 9'h13f;                         // Plus one carries into bit 6
        fill_table(5'h1e);
        h1 = 9'h0a5 + 9'd1;
        h2 = 9'h13f + 9'd1;
        i1 = MODEL_B ? {1'b0, h1[8:4]} : {h1[8:4], 1'b0};
        i2 = MODEL_B ? {1'b1, h2[8:4]} : {h2[8:4], 1'b1};
        wait_phase(3'd7);
        hs = hdump;
        // Busy follows the previous clock's column slot and hdump parity
        for (int n = 0; n < 64; n++) begin
            @(negedge clk);
            checks++;
            assert (!(col_busy1 && col_busy2)) else begin
                $display("Both column busy flags were high at hdump 0x%h", hdump);
                errors++;
            end
            check_value("col_busy1", col_busy1, hs[2:0] < 3'd6 && !hs[0]);
            check_value("col_busy2", col_busy2, hs[2:0] < 3'd6 && hs[0]);
            hs = hdump;
        end
        wait_phase(3'd6);
        check_value("colscr1", colscr1, table_words[i1][8:0]);
        check_value("colscr2", colscr2, table_words[i2][8:0]);
        report_test("column scroll", e);
    endtask

    task automatic test_pixels(input logic alt, input logic flp);
        int e;
        int b;
        logic [8:0]  code;
        logic [3:0]  attr;
        logic [23:0] loaded;
        e = errors;
        @(posedge clk);
        alt_en <= alt;
        flip   <= flp;
        for (int a = 0; a < MAP_WORDS; a++) cpu_write(a[10:0], TILE, 2'b00);
        cpu_idle();
        // Code and attribute as the board models lay them out
        if (MODEL_B && !alt) begin
            code = {TILE[8], TILE[7:0]};
            attr = {TILE[15], TILE[11:9]};
        end else if (MODEL_B) begin
            code = {1'b0, TILE[7:0]};
            attr = {TILE[15], TILE[10:8]};
        end else begin
            code = {1'b0, TILE[7:0]};
            attr = TILE[11:8];
        end
        repeat (3) wait_load(loaded);                 // Fill the attribute pipeline
        for (int k = 0; k < 8; k++) begin
            if (k > 0) wait_phase(k[2:0]);
            b = flp ? k : 7 - k;
            check_value("char_addr", {char_addr[12:4], char_addr[0]}, {code, 1'b0});
            check_value("pxl attr", pxl[6:3], attr);
            check_value("pxl colour", pxl[2:0], {loaded[16 + b], loaded[8 + b], loaded[b]});
        end
        report_test(alt ? "tile pixels, alternate, flipped" : "tile pixels, plain", e);
    endtask

    initial begin
        #(WATCHDOG_CLKS * PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst        <= 1'b1;
        char_cs    <= 1'b0;
        cpu_addr   <= '0;
        cpu_dout   <= '0;
        dsn        <= 2'b11;
        alt_en     <= 1'b0;
        flip       <= 1'b0;
        vrender    <= '0;
        scr1_hscan <= '0;
        scr2_hscan <= '0;
        repeat (RST_CYCLES - 1) @(posedge clk);
        test_reset_state();                           // Still inside reset
        @(posedge clk);
        rst <= 1'b0;
        test_cpu_bytes();
        test_row_scroll();
        test_col_scroll();
        test_pixels(1'b0, 1'b0);
        test_pixels(1'b1, 1'b1);
        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
